// File: sources.f
src/fetch_pkg.sv
src/mem_bus_if.sv
src/icache.sv
src/load_port.sv
src/bus_arbiter.sv
src/fetch_top.sv
bench/mem_model.sv
bench/tb_fetch_top.sv

// File: Makefile
# Verilator build and run for the fetch subsystem

VERILATOR ?= verilator
TOP       ?= tb_fetch_top
LINT_TOP  ?= fetch_top
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# pass only if the log holds the pass message
run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qF '*** PASSED ***' $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/tb_fetch_top.sv
// testbench for the fetch subsystem
// drives fetches and loads, checks results against the memory content rule

`timescale 1ns/10ps

module tb_fetch_top;
   import fetch_pkg::*;

   // cycles any single wait may take
   localparam int TIMEOUT_CYC = 4000;
   localparam int NUM_RAND    = 15;

   logic       clk_i;
   logic       rst_i;
   addr_t      fetch_adr_i;
   logic       fetch_stb_i;
   logic       hit_o;
   hword_t     inst_o;
   word_t      imm_o;
   addr_t      load_adr_i;
   logic       load_req_i;
   logic       load_busy_o;
   word_t      load_data_o;
   logic       load_valid_o;
   addr_t      mem_adr_o;
   logic [1:0] mem_sel_o;
   logic       mem_cyc_o;
   logic       mem_stb_o;
   hword_t     mem_dat_i;
   logic       mem_ack_i;

   integer seed;
   // stimulus side counts
   int     stim_err_cnt;
   int     stim_check_cnt;
   // compare process counts
   int     cmp_err_cnt;
   int     cmp_check_cnt;
   int     test_cnt;
   int     test_fail_cnt;
   int     err_mark;

   // addresses the registered outputs belong to
   addr_t  hit_adr_q;
   addr_t  ld_adr_q;

   addr_t  fetch_list [NUM_RAND];
   addr_t  load_list  [NUM_RAND];
   int     gap_list   [NUM_RAND];

   fetch_top fetch_top_i (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .fetch_adr_i  (fetch_adr_i),
      .fetch_stb_i  (fetch_stb_i),
      .hit_o        (hit_o),
      .inst_o       (inst_o),
      .imm_o        (imm_o),
      .load_adr_i   (load_adr_i),
      .load_req_i   (load_req_i),
      .load_busy_o  (load_busy_o),
      .load_data_o  (load_data_o),
      .load_valid_o (load_valid_o),
      .mem_adr_o    (mem_adr_o),
      .mem_sel_o    (mem_sel_o),
      .mem_cyc_o    (mem_cyc_o),
      .mem_stb_o    (mem_stb_o),
      .mem_dat_i    (mem_dat_i),
      .mem_ack_i    (mem_ack_i)
   );

   mem_model #(.SEED(32'h3577_92fc)) mem_model_i (
      .clk_i (clk_i),
      .rst_i (rst_i),
      .adr_i (mem_adr_o),
      .sel_i (mem_sel_o),
      .cyc_i (mem_cyc_o),
      .stb_i (mem_stb_o),
      .ack_o (mem_ack_i),
      .dat_o (mem_dat_i)
   );

   // 8 ns clock
   initial
   begin
      clk_i = 1'b0;
      forever #4 clk_i = ~clk_i;
   end

   // expected halfword at a byte address
   function automatic hword_t hword_at(input addr_t a);
      return a[16:1] ^ 16'h5a5a;
   endfunction

   // two halfwords after the instruction with the same 32-bit wrap as the bus address
   function automatic word_t imm_after(input addr_t a);
      return {hword_at(a + 32'd2), hword_at(a + 32'd4)};
   endfunction

   // high half at the word address
   function automatic word_t load_word(input addr_t a);
      return {hword_at(a), hword_at(a + 32'd2)};
   endfunction

   // inputs change 1 ns after the edge, so these see last cycle's values
   always @(posedge clk_i)
   begin
      hit_adr_q <= fetch_adr_i;
      if (load_req_i && !load_busy_o)
         ld_adr_q <= load_adr_i;
   end

   // outputs are stable at the falling edge
   always @(negedge clk_i)
   begin
      if (!rst_i && hit_o)
      begin
         cmp_check_cnt++;
         assert (inst_o == hword_at(hit_adr_q))
         else
         begin
            $display("ERR %0t inst_o got %h expected %h", $time, inst_o,
                     hword_at(hit_adr_q));
            cmp_err_cnt++;
         end
         assert (imm_o == imm_after(hit_adr_q))
         else
         begin
            $display("ERR %0t imm_o got %h expected %h", $time, imm_o,
                     imm_after(hit_adr_q));
            cmp_err_cnt++;
         end
      end
      if (!rst_i && load_valid_o)
      begin
         cmp_check_cnt++;
         assert (load_data_o == load_word(ld_adr_q))
         else
         begin
            $display("ERR %0t load_data_o got %h expected %h", $time, load_data_o,
                     load_word(ld_adr_q));
            cmp_err_cnt++;
         end
      end
   end

   task automatic check_bit(input string name, input logic got, input logic exp);
      stim_check_cnt++;
      assert (got === exp)
      else
      begin
         $display("ERR %0t %s got %b expected %b", $time, name, got, exp);
         stim_err_cnt++;
      end
   endtask

   // first is 0 to expect a miss on the first lookup, 1 for a hit, 2 for either
   task automatic fetch_and_wait(input addr_t a, input int first);
      int   n;
      logic done;
      n           = 0;
      done        = 1'b0;
      fetch_adr_i = a;
      fetch_stb_i = 1'b1;
      while (!done && (n < TIMEOUT_CYC))
      begin
         @(posedge clk_i);
         #1;
         if ((n == 0) && (first != 2))
            check_bit("hit_o", hit_o, first == 1);
         if (hit_o)
            done = 1'b1;
         n++;
      end
      if (!done)
      begin
         $display("timeout, fetch at %h never hit within %0d cycles", a, TIMEOUT_CYC);
         stim_err_cnt++;
      end
   endtask

   // wait for the port, pulse the request, wait for the result
   task automatic issue_load(input addr_t a);
      int   n;
      logic done;
      n = 0;
      while (load_busy_o && (n < TIMEOUT_CYC))
      begin
         @(posedge clk_i);
         #1;
         n++;
      end
      if (load_busy_o)
      begin
         $display("timeout, load port stayed busy before load at %h", a);
         stim_err_cnt++;
      end
      else
      begin
         load_adr_i = a;
         load_req_i = 1'b1;
         @(posedge clk_i);
         #1;
         load_req_i = 1'b0;
         n          = 0;
         done       = 1'b0;
         while (!done && (n < TIMEOUT_CYC))
         begin
            if (load_valid_o)
               done = 1'b1;
            else
            begin
               @(posedge clk_i);
               #1;
               n++;
            end
         end
         if (!done)
         begin
            $display("timeout, load at %h never returned data", a);
            stim_err_cnt++;
         end
      end
   endtask

   // settle so the compare process has seen the last result
   task automatic report_test(input string name);
      int total;
      repeat (2) @(posedge clk_i);
      #1;
      total = stim_err_cnt + cmp_err_cnt;
      test_cnt++;
      if (total != err_mark)
      begin
         test_fail_cnt++;
         $display("test %0d %s: FAIL, %0d errors", test_cnt, name, total - err_mark);
      end
      else
         $display("test %0d %s: ok", test_cnt, name);
      err_mark = total;
   endtask

   initial
   begin
      int fi;
      int li;
      seed           = 32'h3577_92fc;
      stim_err_cnt   = 0;
      stim_check_cnt = 0;
      cmp_err_cnt    = 0;
      cmp_check_cnt  = 0;
      test_cnt       = 0;
      test_fail_cnt  = 0;
      err_mark       = 0;
      rst_i          = 1'b1;
      fetch_adr_i    = '0;
      fetch_stb_i    = 1'b0;
      load_adr_i     = '0;
      load_req_i     = 1'b0;

      // random fetches halfword aligned, loads word aligned, same 128 KiB
      for (fi = 0; fi < NUM_RAND; fi++)
      begin
         fetch_list[fi] = addr_t'($random(seed)) & 32'h0001_fffe;
         load_list[fi]  = addr_t'($random(seed)) & 32'h0001_fffc;
         gap_list[fi]   = $random(seed) & 7;
      end

      repeat (10) @(posedge clk_i);
      #1;
      rst_i = 1'b0;

      // outputs idle after reset, valid bits clear
      check_bit("hit_o", hit_o, 1'b0);
      check_bit("load_valid_o", load_valid_o, 1'b0);
      check_bit("load_busy_o", load_busy_o, 1'b0);
      check_bit("mem_cyc_o", mem_cyc_o, 1'b0);
      check_bit("mem_stb_o", mem_stb_o, 1'b0);
      fetch_and_wait(32'h0000_0080, 0);
      report_test("reset and first fetch");

      fetch_and_wait(32'h0000_0200, 0);
      fetch_and_wait(32'h0000_0202, 1);
      report_test("cold miss then hit");

      // offsets 14 and 15, then the last set wrapping to set 0
      fetch_and_wait(32'h0000_043c, 0);
      fetch_and_wait(32'h0000_043e, 1);
      fetch_and_wait(32'h0000_1ffc, 0);
      fetch_and_wait(32'h0000_1ffe, 1);
      fetch_and_wait(32'h0000_2000, 1);
      report_test("straddling fetches");

      // set 8 with tags 1 and 2
      fetch_and_wait(32'h0000_2100, 0);
      fetch_and_wait(32'h0000_4100, 0);
      fetch_and_wait(32'h0000_2100, 0);
      fetch_and_wait(32'h0000_4100, 0);
      report_test("index conflict");

      fork
         fetch_and_wait(32'h0000_6600, 0);
         begin
            repeat (3) @(posedge clk_i);
            #1;
            issue_load(32'h0000_6800);
         end
      join
      report_test("load during fill");

      fork
         begin
            for (fi = 0; fi < NUM_RAND; fi++)
               fetch_and_wait(fetch_list[fi], 2);
         end
         begin
            for (li = 0; li < NUM_RAND; li++)
            begin
               repeat (gap_list[li]) @(posedge clk_i);
               #1;
               issue_load(load_list[li]);
            end
         end
      join
      report_test("random fetches and loads");

      $display("tests %0d, failed %0d, checks %0d, errors %0d", test_cnt, test_fail_cnt,
               stim_check_cnt + cmp_check_cnt, stim_err_cnt + cmp_err_cnt);
      if ((stim_err_cnt + cmp_err_cnt) == 0)
         $display("*** PASSED ***");
      else
         $display("*** FAILED ***");
      $finish;
   end

endmodule

// File: bench/mem_model.sv
// testbench memory slave for the 16-bit fetch bus
// pattern data per halfword, 0 to 3 random wait states before each ack

`timescale 1ns/10ps

module mem_model #(
   parameter int SEED = 32'h3577_92fc
) (
   input  logic        clk_i,
   input  logic        rst_i,
   input  logic [31:0] adr_i,
   input  logic [1:0]  sel_i,
   input  logic        cyc_i,
   input  logic        stb_i,
   output logic        ack_o,
   output logic [15:0] dat_o
);

   integer      seed;
   logic        pending;
   int          wait_cnt;
   logic [15:0] hw;

   // memory content, halfword at byte address a
   function automatic logic [15:0] pattern(input logic [31:0] a);
      return a[16:1] ^ 16'h5a5a;
   endfunction

   // responses change 1 ns after the edge, like every other DUT input
   initial
   begin
      seed     = SEED;
      pending  = 1'b0;
      wait_cnt = 0;
      hw       = '0;
      ack_o    = 1'b0;
      dat_o    = '0;
      forever
      begin
         @(posedge clk_i);
         #1;
         // ack is a single cycle pulse
         ack_o = 1'b0;
         if (rst_i)
            pending = 1'b0;
         else if (cyc_i && stb_i)
         begin
            // new beat, draw its wait states
            if (!pending)
            begin
               wait_cnt = $random(seed) & 3;
               pending  = 1'b1;
            end
            if (wait_cnt == 0)
            begin
               hw      = pattern(adr_i);
               // byte lanes by sel
               dat_o   = {sel_i[1] ? hw[15:8] : 8'h00, sel_i[0] ? hw[7:0] : 8'h00};
               ack_o   = 1'b1;
               pending = 1'b0;
            end
            else
               wait_cnt = wait_cnt - 1;
         end
      end
   end

endmodule

// File: src/fetch_top.sv
// instruction fetch subsystem top
// cache and load port share one 16-bit memory bus through the arbiter

`timescale 1ns/10ps

module fetch_top (
   input  logic              clk_i,
   input  logic              rst_i,
   // core fetch side
   input  fetch_pkg::addr_t  fetch_adr_i,
   input  logic              fetch_stb_i,
   output logic              hit_o,
   output fetch_pkg::hword_t inst_o,
   output fetch_pkg::word_t  imm_o,
   // core load side
   input  fetch_pkg::addr_t  load_adr_i,
   input  logic              load_req_i,
   output logic              load_busy_o,
   output fetch_pkg::word_t  load_data_o,
   output logic              load_valid_o,
   // external memory
   output fetch_pkg::addr_t  mem_adr_o,
   output logic [1:0]        mem_sel_o,
   output logic              mem_cyc_o,
   output logic              mem_stb_o,
   input  fetch_pkg::hword_t mem_dat_i,
   input  logic              mem_ack_i
);

   mem_bus_if cache_bus ();
   mem_bus_if load_bus ();
   mem_bus_if mem_bus ();

   assign mem_adr_o     = mem_bus.adr;
   assign mem_sel_o     = mem_bus.sel;
   assign mem_cyc_o     = mem_bus.cyc;
   assign mem_stb_o     = mem_bus.stb;
   assign mem_bus.ack   = mem_ack_i;
   assign mem_bus.dat_r = mem_dat_i;

   icache icache_i (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .fetch_adr_i (fetch_adr_i),
      .fetch_stb_i (fetch_stb_i),
      .hit_o       (hit_o),
      .inst_o      (inst_o),
      .imm_o       (imm_o),
      .bus_m       (cache_bus.master)
   );

   load_port load_port_i (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .load_adr_i   (load_adr_i),
      .load_req_i   (load_req_i),
      .load_busy_o  (load_busy_o),
      .load_data_o  (load_data_o),
      .load_valid_o (load_valid_o),
      .bus_m        (load_bus.master)
   );

   bus_arbiter bus_arbiter_i (
      .clk_i (clk_i),
      .rst_i (rst_i),
      .m0    (cache_bus.slave),
      .m1    (load_bus.slave),
      .s     (mem_bus.master)
   );

endmodule

// File: src/bus_arbiter.sv
// two master arbiter for the memory bus
// cache on m0, load port on m1, alternating priority on a tie

`timescale 1ns/10ps

module bus_arbiter (
   input  logic      clk_i,
   input  logic      rst_i,
   mem_bus_if.slave  m0,
   mem_bus_if.slave  m1,
   mem_bus_if.master s
);
   import fetch_pkg::*;

   grant_t grant_q;
   // high when m1 wins the next tie
   logic   prio_m1_q;
   logic   own0;
   logic   own1;

   assign own0 = (grant_q == GRANT_CACHE);
   assign own1 = (grant_q == GRANT_LOAD);

   // request mux drives nothing without an owner
   assign s.adr = own1 ? m1.adr : m0.adr;
   assign s.sel = own1 ? m1.sel : m0.sel;
   assign s.cyc = (own0 && m0.cyc) || (own1 && m1.cyc);
   assign s.stb = (own0 && m0.stb) || (own1 && m1.stb);

   // response only to the owner
   assign m0.ack   = own0 && s.ack;
   assign m1.ack   = own1 && s.ack;
   assign m0.dat_r = own0 ? s.dat_r : '0;
   assign m1.dat_r = own1 ? s.dat_r : '0;

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         grant_q   <= GRANT_NONE;
         prio_m1_q <= 1'b0;
      end
      else
      begin
         case (grant_q)
            GRANT_NONE:
            begin
               // a tie goes to the master that lost the previous tie
               if (m0.cyc && (!m1.cyc || !prio_m1_q))
               begin
                  grant_q <= GRANT_CACHE;
                  // only a tie moves the priority
                  if (m1.cyc)
                     prio_m1_q <= 1'b1;
               end
               else if (m1.cyc)
               begin
                  grant_q <= GRANT_LOAD;
                  if (m0.cyc)
                     prio_m1_q <= 1'b0;
               end
            end

            GRANT_CACHE:
            begin
               if (!m0.cyc)
                  grant_q <= GRANT_NONE;
            end

            GRANT_LOAD:
            begin
               if (!m1.cyc)
                  grant_q <= GRANT_NONE;
            end

            default:
            begin
               grant_q <= GRANT_NONE;
            end
         endcase
      end
   end

   a_grant_held : assert property (@(posedge clk_i) disable iff (rst_i)
      s.cyc |=> $stable(grant_q));

endmodule

// File: src/load_port.sv
// uncached load port
// reads one 32-bit word as two halfword beats, high half first

`timescale 1ns/10ps

module load_port (
   input  logic             clk_i,
   input  logic             rst_i,
   input  fetch_pkg::addr_t load_adr_i,
   input  logic             load_req_i,
   output logic             load_busy_o,
   output fetch_pkg::word_t load_data_o,
   output logic             load_valid_o,
   mem_bus_if.master        bus_m
);
   import fetch_pkg::*;

   load_state_t state_q;
   addr_t       adr_q;
   word_t       data_q;
   logic        cyc_q;
   logic        stb_q;

   assign bus_m.adr = adr_q;
   assign bus_m.sel = 2'b11;
   assign bus_m.cyc = cyc_q;
   assign bus_m.stb = stb_q;

   assign load_busy_o  = (state_q != LD_IDLE);
   assign load_valid_o = (state_q == LD_DONE);
   assign load_data_o  = data_q;

   // result halves, high beat then low beat
   always_ff @(posedge clk_i)
   begin
      if (stb_q && bus_m.ack)
      begin
         if (state_q == LD_BEAT_HI)
            data_q[31:16] <= bus_m.dat_r;
         else
            data_q[15:0] <= bus_m.dat_r;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         state_q <= LD_IDLE;
         adr_q   <= '0;
         cyc_q   <= 1'b0;
         stb_q   <= 1'b0;
      end
      else
      begin
         case (state_q)
            LD_IDLE:
            begin
               if (load_req_i)
               begin
                  adr_q   <= load_adr_i;
                  cyc_q   <= 1'b1;
                  stb_q   <= 1'b1;
                  state_q <= LD_BEAT_HI;
               end
            end

            LD_BEAT_HI:
            begin
               if (bus_m.ack)
               begin
                  // drop stb for a cycle but keep cyc
                  stb_q   <= 1'b0;
                  adr_q   <= adr_q + addr_t'(2);
                  state_q <= LD_BEAT_LO;
               end
            end

            LD_BEAT_LO:
            begin
               if (!stb_q)
               begin
                  stb_q <= 1'b1;
               end
               else if (bus_m.ack)
               begin
                  stb_q   <= 1'b0;
                  cyc_q   <= 1'b0;
                  state_q <= LD_DONE;
               end
            end

            // single cycle result pulse
            default:
            begin
               state_q <= LD_IDLE;
            end
         endcase
      end
   end

   a_req_not_busy : assert property (@(posedge clk_i) disable iff (rst_i)
      load_req_i |-> !load_busy_o);

endmodule

// File: src/icache.sv
// direct mapped instruction cache, 256 lines of 16 halfwords
// returns the instruction and the two halfwords after it, fills lines over the memory bus

`timescale 1ns/10ps

module icache (
   input  logic              clk_i,
   input  logic              rst_i,
   input  fetch_pkg::addr_t  fetch_adr_i,
   input  logic              fetch_stb_i,
   output logic              hit_o,
   output fetch_pkg::hword_t inst_o,
   output fetch_pkg::word_t  imm_o,
   mem_bus_if.master         bus_m
);
   import fetch_pkg::*;

   // storage
   logic [NUM_SETS-1:0] valid_q;
   tag_t                tag_q  [NUM_SETS];
   hword_t              line_q [NUM_SETS*LINE_HW];

   // address split of the current fetch
   tag_t    cur_tag;
   index_t  cur_idx;
   offset_t cur_off;
   addr_t   cur_line_adr;

   // the following line, used when the fetch straddles
   addr_t   next_line_adr;
   tag_t    next_tag;
   index_t  next_idx;

   logic    straddle;
   logic    hit0;
   logic    hit1;
   addr_t   miss_adr;
   index_t  miss_idx;

   // flat halfword positions in the line array
   logic [INDEX_W+OFFSET_W-1:0] hw0;
   logic [INDEX_W+OFFSET_W-1:0] hw1;
   logic [INDEX_W+OFFSET_W-1:0] hw2;

   // fill machine
   icache_state_t state_q;
   addr_t         fill_adr_q;
   logic          cyc_q;
   logic          stb_q;
   tag_t          fill_tag;
   index_t        fill_idx;
   logic          last_beat;

   assign cur_off      = fetch_adr_i[1 +: OFFSET_W];
   assign cur_idx      = fetch_adr_i[OFFSET_W+1 +: INDEX_W];
   assign cur_tag      = fetch_adr_i[INDEX_W+OFFSET_W+1 +: TAG_W];
   assign cur_line_adr = {fetch_adr_i[31:5], 5'b00000};

   // next line gets its own tag and index so the last set wraps correctly
   assign next_line_adr = cur_line_adr + addr_t'(LINE_HW * 2);
   assign next_idx      = next_line_adr[OFFSET_W+1 +: INDEX_W];
   assign next_tag      = next_line_adr[INDEX_W+OFFSET_W+1 +: TAG_W];

   // offsets 14 and 15 need halfwords from the following line
   assign straddle = (cur_off >= offset_t'(LINE_HW - 2));
   assign hit0     = valid_q[cur_idx] && (tag_q[cur_idx] == cur_tag);
   assign hit1     = !straddle || (valid_q[next_idx] && (tag_q[next_idx] == next_tag));

   // first missing line, current line has precedence
   assign miss_adr = hit0 ? next_line_adr : cur_line_adr;
   assign miss_idx = miss_adr[OFFSET_W+1 +: INDEX_W];

   // array position wraps from set 255 to set 0, same as next_idx
   assign hw0 = {cur_idx, cur_off};
   assign hw1 = (INDEX_W+OFFSET_W)'(hw0 + 1);
   assign hw2 = (INDEX_W+OFFSET_W)'(hw0 + 2);

   assign fill_idx  = fill_adr_q[OFFSET_W+1 +: INDEX_W];
   assign fill_tag  = fill_adr_q[INDEX_W+OFFSET_W+1 +: TAG_W];
   assign last_beat = (fill_adr_q[1 +: OFFSET_W] == offset_t'(LINE_HW - 1));

   assign bus_m.adr = fill_adr_q;
   assign bus_m.sel = 2'b11;
   assign bus_m.cyc = cyc_q;
   assign bus_m.stb = stb_q;

   // registered lookup, reflects last cycle's address
   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         hit_o <= 1'b0;
      end
      else
      begin
         hit_o <= fetch_stb_i && hit0 && hit1;
      end
   end

   always_ff @(posedge clk_i)
   begin
      inst_o <= line_q[hw0];
      imm_o  <= {line_q[hw1], line_q[hw2]};
   end

   // line data on every beat, tag with the last one
   always_ff @(posedge clk_i)
   begin
      if ((state_q == IC_FILL) && bus_m.ack)
      begin
         line_q[fill_adr_q[1 +: INDEX_W+OFFSET_W]] <= bus_m.dat_r;
         if (last_beat)
         begin
            tag_q[fill_idx] <= fill_tag;
         end
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         state_q    <= IC_IDLE;
         valid_q    <= '0;
         cyc_q      <= 1'b0;
         stb_q      <= 1'b0;
         fill_adr_q <= '0;
      end
      else
      begin
         case (state_q)
            IC_IDLE:
            begin
               if (fetch_stb_i && !(hit0 && hit1))
               begin
                  // line is invalid while it is being overwritten
                  valid_q[miss_idx] <= 1'b0;
                  fill_adr_q        <= miss_adr;
                  cyc_q             <= 1'b1;
                  stb_q             <= 1'b1;
                  state_q           <= IC_FILL;
               end
            end

            IC_FILL:
            begin
               // ack only reaches us once the arbiter has granted the bus
               if (bus_m.ack)
               begin
                  stb_q      <= 1'b0;
                  fill_adr_q <= fill_adr_q + addr_t'(2);
                  if (last_beat)
                  begin
                     cyc_q             <= 1'b0;
                     valid_q[fill_idx] <= 1'b1;
                     state_q           <= IC_NEXT_LINE;
                  end
                  else
                  begin
                     state_q <= IC_FILL_WAIT;
                  end
               end
            end

            // one idle cycle between beats
            IC_FILL_WAIT:
            begin
               stb_q   <= 1'b1;
               state_q <= IC_FILL;
            end

            IC_NEXT_LINE:
            begin
               // straddling fetch may still miss on the following line
               if (fetch_stb_i && hit0 && !hit1)
               begin
                  valid_q[next_idx] <= 1'b0;
                  fill_adr_q        <= next_line_adr;
                  cyc_q             <= 1'b1;
                  stb_q             <= 1'b1;
                  state_q           <= IC_FILL;
               end
               else
               begin
                  state_q <= IC_IDLE;
               end
            end

            default:
            begin
               state_q <= IC_IDLE;
            end
         endcase
      end
   end

   a_stb_in_cyc : assert property (@(posedge clk_i) disable iff (rst_i)
      bus_m.stb |-> bus_m.cyc);

   a_cyc_busy : assert property (@(posedge clk_i) disable iff (rst_i)
      bus_m.cyc |-> (state_q != IC_IDLE));

endmodule

// File: src/mem_bus_if.sv
// single 16-bit memory bus, Wishbone style cyc/stb/ack
// one halfword beat per ack, read only

`timescale 1ns/10ps

interface mem_bus_if;
   import fetch_pkg::*;

   // request side, driven by the master
   addr_t       adr;
   logic [1:0]  sel;
   logic        cyc;
   logic        stb;

   // response side, driven by the slave
   logic        ack;
   hword_t      dat_r;

   modport master (
      output adr,
      output sel,
      output cyc,
      output stb,
      input  ack,
      input  dat_r
   );

   modport slave (
      input  adr,
      input  sel,
      input  cyc,
      input  stb,
      output ack,
      output dat_r
   );

endinterface

// File: src/fetch_pkg.sv
// fetch subsystem package
// cache geometry, width types and the FSM encodings shared by the fetch blocks

package fetch_pkg;

   // 8 KiB direct mapped, 256 lines of 32 bytes
   localparam int NUM_SETS = 256;
   // halfwords per line
   localparam int LINE_HW  = 16;
   localparam int INDEX_W  = 8;
   // halfword offset within a line, byte bit 0 is dropped
   localparam int OFFSET_W = 4;
   // 32 - 8 - 4 - 1
   localparam int TAG_W    = 19;

   // byte address
   typedef logic [31:0]         addr_t;
   // one instruction or one bus beat
   typedef logic [15:0]         hword_t;
   // immediate or load result
   typedef logic [31:0]         word_t;
   typedef logic [TAG_W-1:0]    tag_t;
   typedef logic [INDEX_W-1:0]  index_t;
   typedef logic [OFFSET_W-1:0] offset_t;

   // cache fill machine
   typedef enum logic [1:0] {
      IC_IDLE,
      IC_FILL,
      IC_FILL_WAIT,
      IC_NEXT_LINE
   } icache_state_t;

   // uncached load machine, high half first
   typedef enum logic [1:0] {
      LD_IDLE,
      LD_BEAT_HI,
      LD_BEAT_LO,
      LD_DONE
   } load_state_t;

   // bus owner
   typedef enum logic [1:0] {
      GRANT_NONE,
      GRANT_CACHE,
      GRANT_LOAD
   } grant_t;

endpackage
